// File: hw/adc_regs_pkg.sv
// ==========================================================
// ADC front end register map and SPI settings
// Register addresses, reset values, field widths and the
// states of the SPI master
// ==========================================================

package adc_regs_pkg;

    // Register port widths
    localparam int addr_width     = 4;
    localparam int reg_data_width = 16;

    // SCLK half period in system clock cycles
    localparam int div_width     = 8;
    localparam int clk_div_reset = 2;

    // Transfer length in bits, clamped on write
    localparam int len_width      = 5;
    localparam int xfer_len_reset = 16;
    localparam int min_xfer_len   = 4;
    localparam int max_xfer_len   = 16;

    typedef enum logic [addr_width-1:0] {
        CTRL     = 4'h0,
        CLK_DIV  = 4'h1,
        XFER_LEN = 4'h2,
        DEST0    = 4'h3,
        DEST1    = 4'h4,
        DEST2    = 4'h5
    } reg_addr_e;

    // SELECT covers the first low phase after ss falls
    typedef enum logic [2:0] {
        IDLE,
        SELECT,
        SHIFT,
        DESELECT,
        HOLD
    } spi_state_e;

endpackage

// File: hw/adc_stream_pkg.sv
// ==========================================================
// ADC front end stream and frame description
// Channel count, beat field widths and serializer states
// ==========================================================

package adc_stream_pkg;

    // One MISO line per channel
    localparam int n_channels = 3;

    // Data field of a beat, wide enough for the longest transfer
    localparam int sample_width = 16;

    // Destination tag carried with each beat
    localparam int dest_width = 8;

    // Index of the channel being emitted
    localparam int chan_width = 2;

    // Number of valid data bits reported with each beat
    localparam int size_width = 5;

    typedef enum logic {
        EMPTY,
        EMIT
    } ser_state_e;

endpackage

// File: hw/spi_config_regs.sv
// ==========================================================
// Write-only configuration bank of the ADC front end
// Holds the enable bit, SCLK divider, transfer length and
// the per-channel destination table
// ==========================================================
`timescale 1ns/10ps

module spi_config_regs (
    input  logic                                   clock,
    input  logic                                   rst,
    input  logic                                   reg_valid,
    output logic                                   reg_ready,
    input  logic [adc_regs_pkg::addr_width-1:0]    reg_addr,
    input  logic [adc_regs_pkg::reg_data_width-1:0] reg_wdata,
    output logic                                   enable,
    output logic [adc_regs_pkg::div_width-1:0]     clk_div,
    output logic [adc_regs_pkg::len_width-1:0]     xfer_len,
    output logic [adc_stream_pkg::n_channels*adc_stream_pkg::dest_width-1:0] dest_table
);

    localparam int dw = adc_stream_pkg::dest_width;

    logic                               wr_en;
    logic [adc_regs_pkg::div_width-1:0] div_wr;
    logic [adc_regs_pkg::len_width-1:0] len_wr;

    // Writes are taken in every cycle outside of reset
    assign reg_ready = !rst;
    assign wr_en     = reg_valid && reg_ready;

    // A zero divider would stall the SPI master, so it becomes one
    always_comb begin
        div_wr = reg_wdata[adc_regs_pkg::div_width-1:0];
        if (div_wr == '0) begin
            div_wr = 1;
        end
    end

    always_comb begin
        if (reg_wdata < adc_regs_pkg::min_xfer_len) begin
            len_wr = adc_regs_pkg::len_width'(adc_regs_pkg::min_xfer_len);
        end else if (reg_wdata > adc_regs_pkg::max_xfer_len) begin
            len_wr = adc_regs_pkg::len_width'(adc_regs_pkg::max_xfer_len);
        end else begin
            len_wr = reg_wdata[adc_regs_pkg::len_width-1:0];
        end
    end

    always_ff @(posedge clock) begin
        if (rst) begin
            enable    <= 1'b0;
            clk_div   <= adc_regs_pkg::div_width'(adc_regs_pkg::clk_div_reset);
            xfer_len  <= adc_regs_pkg::len_width'(adc_regs_pkg::xfer_len_reset);
            for (int i = 0; i < adc_stream_pkg::n_channels; i++) begin
                dest_table[i*dw +: dw] <= dw'(i);
            end
        end else begin
            if (wr_en) begin
                // Unknown addresses fall through and the write is dropped
                case (adc_regs_pkg::reg_addr_e'(reg_addr))
                    adc_regs_pkg::CTRL:     enable <= reg_wdata[0];
                    adc_regs_pkg::CLK_DIV:  clk_div <= div_wr;
                    adc_regs_pkg::XFER_LEN: xfer_len <= len_wr;
                    adc_regs_pkg::DEST0:    dest_table[0*dw +: dw] <= reg_wdata[dw-1:0];
                    adc_regs_pkg::DEST1:    dest_table[1*dw +: dw] <= reg_wdata[dw-1:0];
                    adc_regs_pkg::DEST2:    dest_table[2*dw +: dw] <= reg_wdata[dw-1:0];
                    default: ;
                endcase
            end
        end
    end

    // The SPI master counts up to clk_div and a zero would never end a phase
    a_clk_div_nonzero : assert property (
        @(posedge clock) disable iff (rst) clk_div != '0
    );

endmodule

// File: hw/spi_multi_miso_master.sv
// ==========================================================
// SPI master with one MISO line per ADC channel
// Runs one transfer per sample strike and shifts all lines
// in parallel into a frame that is held until taken
// ==========================================================
`timescale 1ns/10ps

module spi_multi_miso_master (
    input  logic                                    clock,
    input  logic                                    rst,
    input  logic                                    enable,
    input  logic [adc_regs_pkg::div_width-1:0]      clk_div,
    input  logic [adc_regs_pkg::len_width-1:0]      xfer_len,
    input  logic                                    sample,
    input  logic [adc_stream_pkg::n_channels-1:0]   miso,
    output logic                                    sclk,
    output logic                                    ss,
    output logic                                    frame_valid,
    input  logic                                    frame_ready,
    output logic [adc_stream_pkg::n_channels*adc_stream_pkg::sample_width-1:0] frame_data
);

    localparam int sw = adc_stream_pkg::sample_width;

    adc_regs_pkg::spi_state_e state;

    // Settings latched at the start of a transfer
    logic [adc_regs_pkg::div_width-1:0] div_q;
    logic [adc_regs_pkg::len_width-1:0] len_q;

    logic [adc_regs_pkg::div_width-1:0] div_cnt;
    logic [adc_regs_pkg::len_width-1:0] bit_cnt;
    logic                               phase_done;

    assign phase_done = (div_cnt == div_q - 1'b1);

    always_ff @(posedge clock) begin
        if (rst) begin
            state       <= adc_regs_pkg::IDLE;
            ss          <= 1'b1;
            sclk        <= 1'b0;
            frame_valid <= 1'b0;
            div_cnt     <= '0;
            bit_cnt     <= '0;
            div_q       <= '0;
            len_q       <= '0;
        end else begin
            case (state)
                adc_regs_pkg::IDLE: begin
                    if (sample && enable) begin
                        div_q   <= clk_div;
                        len_q   <= xfer_len;
                        div_cnt <= '0;
                        bit_cnt <= '0;
                        ss      <= 1'b0;
                        state   <= adc_regs_pkg::SELECT;
                    end
                end
                adc_regs_pkg::SELECT: begin
                    // First low phase, the ADCs drive their MSB here
                    if (phase_done) begin
                        div_cnt <= '0;
                        sclk    <= 1'b1;
                        state   <= adc_regs_pkg::SHIFT;
                    end else begin
                        div_cnt <= div_cnt + 1'b1;
                    end
                end
                adc_regs_pkg::SHIFT: begin
                    if (phase_done) begin
                        div_cnt <= '0;
                        sclk    <= ~sclk;
                        if (sclk) begin
                            bit_cnt <= bit_cnt + 1'b1;
                            if (bit_cnt == len_q - 1'b1) begin
                                state <= adc_regs_pkg::DESELECT;
                            end
                        end
                    end else begin
                        div_cnt <= div_cnt + 1'b1;
                    end
                end
                adc_regs_pkg::DESELECT: begin
                    if (phase_done) begin
                        div_cnt <= '0;
                        ss      <= 1'b1;
                        state   <= adc_regs_pkg::HOLD;
                    end else begin
                        div_cnt <= div_cnt + 1'b1;
                    end
                end
                adc_regs_pkg::HOLD: begin
                    // frame_valid follows ss by one cycle
                    if (frame_valid && frame_ready) begin
                        frame_valid <= 1'b0;
                        state       <= adc_regs_pkg::IDLE;
                    end else begin
                        frame_valid <= 1'b1;
                    end
                end
                default: state <= adc_regs_pkg::IDLE;
            endcase
        end
    end

    // Shift registers, cleared at the start so the result is right-justified
    always_ff @(posedge clock) begin
        for (int ch = 0; ch < adc_stream_pkg::n_channels; ch++) begin
            if (state == adc_regs_pkg::IDLE && sample && enable) begin
                frame_data[ch*sw +: sw] <= '0;
            end else if (!sclk && phase_done &&
                         (state == adc_regs_pkg::SELECT || state == adc_regs_pkg::SHIFT)) begin
                frame_data[ch*sw +: sw] <= {frame_data[ch*sw +: sw-1], miso[ch]};
            end
        end
    end

    a_sclk_idle_low : assert property (
        @(posedge clock) disable iff (rst) ss |-> !sclk
    );

    a_frame_stable : assert property (
        @(posedge clock) disable iff (rst)
        frame_valid && !frame_ready |=> $stable(frame_data)
    );

endmodule

// File: hw/adc_channel_serializer.sv
// ==========================================================
// Channel serializer of the ADC front end
// Buffers one frame and emits one tagged beat per channel,
// stalling on stream back-pressure
// ==========================================================
`timescale 1ns/10ps

module adc_channel_serializer (
    input  logic                                     clock,
    input  logic                                     rst,
    input  logic                                     frame_valid,
    output logic                                     frame_ready,
    input  logic [adc_stream_pkg::n_channels*adc_stream_pkg::sample_width-1:0] frame_data,
    input  logic [adc_regs_pkg::len_width-1:0]       xfer_len,
    input  logic [adc_stream_pkg::n_channels*adc_stream_pkg::dest_width-1:0] dest_table,
    output logic                                     m_valid,
    input  logic                                     m_ready,
    output logic [adc_stream_pkg::sample_width-1:0]  m_data,
    output logic [adc_stream_pkg::dest_width-1:0]    m_dest,
    output logic [adc_stream_pkg::size_width-1:0]    m_size,
    output logic                                     m_last
);

    localparam int sw = adc_stream_pkg::sample_width;
    localparam int dw = adc_stream_pkg::dest_width;

    adc_stream_pkg::ser_state_e state;

    logic [adc_stream_pkg::n_channels*sw-1:0] frame_q;
    logic [adc_stream_pkg::n_channels*dw-1:0] dest_q;
    logic [adc_stream_pkg::chan_width-1:0]    chan;
    logic                                     beat_done;
    logic                                     capture;

    assign beat_done   = m_valid && m_ready;
    assign frame_ready = (state == adc_stream_pkg::EMPTY) || (beat_done && m_last);
    assign capture     = frame_valid && frame_ready;

    assign m_data = frame_q[int'(chan)*sw +: sw];
    assign m_dest = dest_q[int'(chan)*dw +: dw];
    assign m_last = (chan == adc_stream_pkg::chan_width'(adc_stream_pkg::n_channels - 1));

    always_ff @(posedge clock) begin
        if (rst) begin
            state   <= adc_stream_pkg::EMPTY;
            m_valid <= 1'b0;
            chan    <= '0;
        end else if (capture) begin
            // A new frame can follow the last beat without a gap
            state   <= adc_stream_pkg::EMIT;
            m_valid <= 1'b1;
            chan    <= '0;
        end else if (beat_done) begin
            if (m_last) begin
                state   <= adc_stream_pkg::EMPTY;
                m_valid <= 1'b0;
                chan    <= '0;
            end else begin
                chan <= chan + 1'b1;
            end
        end
    end

    // Destinations are taken with the frame so a stalled beat keeps its tag
    always_ff @(posedge clock) begin
        if (capture) begin
            frame_q <= frame_data;
            dest_q  <= dest_table;
            m_size  <= adc_stream_pkg::size_width'(xfer_len);
        end
    end

    a_no_valid_when_empty : assert property (
        @(posedge clock) disable iff (rst)
        state == adc_stream_pkg::EMPTY |-> !m_valid
    );

endmodule

// File: hw/spi_adc_frontend.sv
// ==========================================================
// Multi-channel SPI ADC front end
// Register bank, parallel-MISO SPI master and the channel
// serializer that feeds the output stream
// ==========================================================
`timescale 1ns/10ps

module spi_adc_frontend (
    input  logic                                     clock,
    input  logic                                     rst,
    input  logic                                     reg_valid,
    output logic                                     reg_ready,
    input  logic [adc_regs_pkg::addr_width-1:0]      reg_addr,
    input  logic [adc_regs_pkg::reg_data_width-1:0]  reg_wdata,
    input  logic                                     sample,
    input  logic [adc_stream_pkg::n_channels-1:0]    miso,
    output logic                                     sclk,
    output logic                                     ss,
    output logic                                     m_valid,
    input  logic                                     m_ready,
    output logic [adc_stream_pkg::sample_width-1:0]  m_data,
    output logic [adc_stream_pkg::dest_width-1:0]    m_dest,
    output logic [adc_stream_pkg::size_width-1:0]    m_size,
    output logic                                     m_last
);

    logic                                enable;
    logic [adc_regs_pkg::div_width-1:0]  clk_div;
    logic [adc_regs_pkg::len_width-1:0]  xfer_len;
    logic [adc_stream_pkg::n_channels*adc_stream_pkg::dest_width-1:0]   dest_table;
    logic                                frame_valid;
    logic                                frame_ready;
    logic [adc_stream_pkg::n_channels*adc_stream_pkg::sample_width-1:0] frame_data;

    spi_config_regs u_regs (
        .clock      (clock),
        .rst        (rst),
        .reg_valid  (reg_valid),
        .reg_ready  (reg_ready),
        .reg_addr   (reg_addr),
        .reg_wdata  (reg_wdata),
        .enable     (enable),
        .clk_div    (clk_div),
        .xfer_len   (xfer_len),
        .dest_table (dest_table)
    );

    spi_multi_miso_master u_spi (
        .clock       (clock),
        .rst         (rst),
        .enable      (enable),
        .clk_div     (clk_div),
        .xfer_len    (xfer_len),
        .sample      (sample),
        .miso        (miso),
        .sclk        (sclk),
        .ss          (ss),
        .frame_valid (frame_valid),
        .frame_ready (frame_ready),
        .frame_data  (frame_data)
    );

    adc_channel_serializer u_ser (
        .clock       (clock),
        .rst         (rst),
        .frame_valid (frame_valid),
        .frame_ready (frame_ready),
        .frame_data  (frame_data),
        .xfer_len    (xfer_len),
        .dest_table  (dest_table),
        .m_valid     (m_valid),
        .m_ready     (m_ready),
        .m_data      (m_data),
        .m_dest      (m_dest),
        .m_size      (m_size),
        .m_last      (m_last)
    );

endmodule

// File: bench/spi_adc_model.sv
// ==========================================================
// Behavioral bank of SPI ADCs sharing ss and sclk
// Each channel shifts out its loaded value MSB first on its
// own MISO line, one bit per falling sclk edge
// ==========================================================
`timescale 1ns/10ps

module spi_adc_model (
    input  logic                                   sclk,
    input  logic                                   ss,
    input  logic [adc_regs_pkg::len_width-1:0]     xfer_len,
    input  logic [adc_stream_pkg::n_channels*adc_stream_pkg::sample_width-1:0] values,
    output logic [adc_stream_pkg::n_channels-1:0]  miso
);

    localparam int sw = adc_stream_pkg::sample_width;

    // Index of the bit currently on the MISO lines, negative once all are out
    int bit_idx;

    task automatic drive_lines();
        for (int ch = 0; ch < adc_stream_pkg::n_channels; ch++) begin
            if (bit_idx >= 0) begin
                miso[ch] = values[ch*sw + bit_idx];
            end else begin
                miso[ch] = 1'b0;
            end
        end
    endtask

    initial begin
        miso    = '0;
        bit_idx = -1;
    end

    // The top bit of the low xfer_len bits is ready before the first rising edge
    always @(negedge ss) begin
        bit_idx = int'(xfer_len) - 1;
        drive_lines();
    end

    always @(negedge sclk) begin
        if (ss === 1'b0) begin
            bit_idx = bit_idx - 1;
            drive_lines();
        end
    end

endmodule

// File: bench/tb_spi_adc_frontend.sv
// ==========================================================
// Testbench of the multi-channel SPI ADC front end
// Strikes frames against a bank of ADC models and checks
// every stream beat against a reference function
// ==========================================================
`timescale 1ns/10ps

module tb_spi_adc_frontend;

    localparam int nch        = adc_stream_pkg::n_channels;
    localparam int sw         = adc_stream_pkg::sample_width;
    localparam int dw         = adc_stream_pkg::dest_width;
    localparam int size_w     = adc_stream_pkg::size_width;
    localparam int beat_w     = sw + dw + size_w + 1;
    localparam int wait_limit = 2000;

    logic                                  clock;
    logic                                  rst;
    logic                                  reg_valid;
    logic                                  reg_ready;
    logic [adc_regs_pkg::addr_width-1:0]   reg_addr;
    logic [adc_regs_pkg::reg_data_width-1:0] reg_wdata;
    logic                                  sample;
    logic [nch-1:0]                        miso;
    logic                                  sclk;
    logic                                  ss;
    logic                                  m_valid;
    logic                                  m_ready;
    logic [sw-1:0]                         m_data;
    logic [dw-1:0]                         m_dest;
    logic [size_w-1:0]                     m_size;
    logic                                  m_last;

    // Expected configuration of the DUT, kept alongside every register write
    logic [adc_regs_pkg::div_width-1:0]    cfg_div;
    logic [adc_regs_pkg::len_width-1:0]    cfg_len;
    logic [nch*dw-1:0]                     cfg_dest;
    logic [nch*sw-1:0]                     chan_vals;

    logic [15:0]                           lfsr_state;
    logic                                  random_ready;
    logic [beat_w-1:0]                     exp_q[$];
    logic [beat_w-1:0]                     held_beat;
    logic                                  stalled;
    logic                                  prev_ss;
    logic                                  prev_sclk;
    int                                    run_len;
    string                                 test_name;

    spi_adc_frontend u_dut (
        .clock     (clock),
        .rst       (rst),
        .reg_valid (reg_valid),
        .reg_ready (reg_ready),
        .reg_addr  (reg_addr),
        .reg_wdata (reg_wdata),
        .sample    (sample),
        .miso      (miso),
        .sclk      (sclk),
        .ss        (ss),
        .m_valid   (m_valid),
        .m_ready   (m_ready),
        .m_data    (m_data),
        .m_dest    (m_dest),
        .m_size    (m_size),
        .m_last    (m_last)
    );

    spi_adc_model u_adc (
        .sclk     (sclk),
        .ss       (ss),
        .xfer_len (cfg_len),
        .values   (chan_vals),
        .miso     (miso)
    );

    initial begin
        clock = 1'b0;
        forever #5 clock = ~clock;
    end

    // Fibonacci LFSR with taps 16, 14, 13 and 11
    function automatic logic next_random_bit();
        logic fb;
        fb = lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10];
        next_random_bit = lfsr_state[15];
        lfsr_state = {lfsr_state[14:0], fb};
    endfunction

    function automatic logic [sw-1:0] random_sample();
        logic [sw-1:0] value;
        value = '0;
        for (int i = 0; i < sw; i++) begin
            value = {value[sw-2:0], next_random_bit()};
        end
        random_sample = value;
    endfunction

    // Packed as data, dest, size and last, from the MSB down
    function automatic logic [beat_w-1:0] expected_beat(
        input int                        ch,
        input logic [nch*sw-1:0]         vals,
        input logic [size_w-1:0]         len,
        input logic [nch*dw-1:0]         dests
    );
        logic [sw-1:0] mask;
        logic          last;
        mask = sw'((32'd1 << len) - 1);
        last = (ch == nch - 1);
        expected_beat = {vals[ch*sw +: sw] & mask, dests[ch*dw +: dw], len, last};
    endfunction

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (expected !== actual) begin
            $display("[FAIL] %s expected 0x%0h actual 0x%0h", name, expected, actual);
            $display("Simulation FAILED");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("Simulation FAILED");
        $fatal(1, "run aborted");
    endtask

    task automatic write_reg(input adc_regs_pkg::reg_addr_e addr, input logic [15:0] data);
        int waited;
        waited = 0;
        @(posedge clock);
        reg_valid <= 1'b1;
        reg_addr  <= addr;
        reg_wdata <= data;
        do begin
            @(posedge clock);
            waited++;
            if (waited > wait_limit) begin
                abort_run("Register write was never accepted");
            end
        end while (!reg_ready);
        reg_valid <= 1'b0;
    endtask

    task automatic apply_config(input logic [7:0] div, input logic [4:0] len,
                                input logic [nch*dw-1:0] dests);
        write_reg(adc_regs_pkg::CLK_DIV, 16'(div));
        write_reg(adc_regs_pkg::XFER_LEN, 16'(len));
        write_reg(adc_regs_pkg::DEST0, 16'(dests[0*dw +: dw]));
        write_reg(adc_regs_pkg::DEST1, 16'(dests[1*dw +: dw]));
        write_reg(adc_regs_pkg::DEST2, 16'(dests[2*dw +: dw]));
        cfg_div  = (div == 0) ? 8'd1 : div;
        cfg_len  = (len < adc_regs_pkg::min_xfer_len) ? 5'(adc_regs_pkg::min_xfer_len) :
                   (len > adc_regs_pkg::max_xfer_len) ? 5'(adc_regs_pkg::max_xfer_len) : len;
        cfg_dest = dests;
    endtask

    task automatic wait_ss(input logic level, input string reason);
        int waited;
        waited = 0;
        do begin
            @(negedge clock);
            waited++;
            if (waited > wait_limit) begin
                abort_run(reason);
            end
        end while (ss !== level);
    endtask

    task automatic wait_backlog(input int max_beats);
        int waited;
        waited = 0;
        do begin
            @(negedge clock);
            waited++;
            if (waited > wait_limit) begin
                abort_run("Expected beats never arrived on the stream");
            end
        end while (exp_q.size() > max_beats);
    endtask

    task automatic strike(input logic accepted);
        @(posedge clock);
        sample <= 1'b1;
        @(posedge clock);
        sample <= 1'b0;
        if (accepted) begin
            for (int ch = 0; ch < nch; ch++) begin
                exp_q.push_back(expected_beat(ch, chan_vals, cfg_len, cfg_dest));
            end
        end
    endtask

    // Strikes once the master is idle and at most one frame is still pending
    task automatic run_frame();
        wait_ss(1'b1, "ss never rose after a transfer");
        repeat (3) @(posedge clock);
        wait_backlog(nch);
        @(negedge clock);
        for (int ch = 0; ch < nch; ch++) begin
            chan_vals[ch*sw +: sw] = random_sample();
        end
        strike(1'b1);
    endtask

    task automatic watch_idle(input int cycles);
        repeat (cycles) begin
            @(negedge clock);
            check_value({test_name, " ss idle"}, 1, ss);
            check_value({test_name, " no beat"}, 0, m_valid);
        end
    endtask

    always @(posedge clock) begin
        m_ready <= random_ready ? next_random_bit() : 1'b1;
    end

    // Compares each moving beat with the head of the queue
    always @(posedge clock) begin : beat_check
        logic [beat_w-1:0] seen;
        logic [beat_w-1:0] expected;
        seen = {m_data, m_dest, m_size, m_last};
        if (rst) begin
            stalled <= 1'b0;
        end else begin
            if (stalled) begin
                check_value({test_name, " stall hold"}, {1'b1, held_beat}, {m_valid, seen});
            end
            if (m_valid && m_ready) begin
                if (exp_q.size() == 0) begin
                    abort_run("A beat arrived with no frame pending");
                end
                expected = exp_q.pop_front();
                check_value({test_name, " data"}, expected[1+size_w+dw +: sw], m_data);
                check_value({test_name, " dest"}, expected[1+size_w +: dw], m_dest);
                check_value({test_name, " size"}, expected[1 +: size_w], m_size);
                check_value({test_name, " last"}, expected[0], m_last);
            end
            stalled   <= m_valid && !m_ready;
            held_beat <= seen;
        end
    end

    // Every sclk phase while selected lasts clk_div cycles
    always @(posedge clock) begin
        if (rst) begin
            prev_ss   <= 1'b1;
            prev_sclk <= 1'b0;
            run_len   <= 0;
        end else begin
            if (!ss) begin
                if (sclk == prev_sclk) begin
                    run_len <= run_len + 1;
                end else begin
                    check_value("sclk phase", cfg_div, run_len);
                    run_len <= 1;
                end
            end else begin
                if (!prev_ss) begin
                    check_value("sclk phase", cfg_div, run_len);
                end
                run_len <= 0;
            end
            prev_ss   <= ss;
            prev_sclk <= sclk;
        end
    end

    initial begin
        lfsr_state   = 16'd92;
        random_ready = 1'b0;
        rst          = 1'b1;
        reg_valid    = 1'b0;
        reg_addr     = '0;
        reg_wdata    = '0;
        sample       = 1'b0;
        m_ready      = 1'b0;
        chan_vals    = '0;
        cfg_div      = 8'(adc_regs_pkg::clk_div_reset);
        cfg_len      = 5'(adc_regs_pkg::xfer_len_reset);
        cfg_dest     = {8'd2, 8'd1, 8'd0};
        test_name    = "reset state";
        repeat (5) @(posedge clock);
        rst <= 1'b0;

        @(negedge clock);
        check_value("reset m_valid", 0, m_valid);
        check_value("reset ss", 1, ss);
        check_value("reset sclk", 0, sclk);
        check_value("reset reg_ready", 1, reg_ready);
        strike(1'b0);
        watch_idle(40);

        test_name = "basic frame";
        write_reg(adc_regs_pkg::CTRL, 16'd1);
        run_frame();
        wait_backlog(0);

        test_name = "changed configuration";
        apply_config(8'd3, 5'd12, {8'h63, 8'h42, 8'h21});
        run_frame();
        run_frame();
        wait_backlog(0);

        test_name = "back-pressure";
        random_ready <= 1'b1;
        repeat (6) run_frame();
        wait_backlog(0);

        // Pulses during a running transfer must not add a frame
        test_name = "ignored strikes";
        run_frame();
        wait_ss(1'b0, "ss never fell after a strike");
        strike(1'b0);
        strike(1'b0);
        run_frame();
        wait_backlog(0);
        random_ready <= 1'b0;
        watch_idle(60);

        $display("Simulation PASSED");
        $finish;
    end

endmodule

// File: compile.f
hw/adc_regs_pkg.sv
hw/adc_stream_pkg.sv
hw/spi_config_regs.sv
hw/spi_multi_miso_master.sv
hw/adc_channel_serializer.sv
hw/spi_adc_frontend.sv
bench/spi_adc_model.sv
bench/tb_spi_adc_frontend.sv

// File: Bender.yml
package:
  name: spi_adc_frontend

sources:
  - hw/adc_regs_pkg.sv
  - hw/adc_stream_pkg.sv
  - hw/spi_config_regs.sv
  - hw/spi_multi_miso_master.sv
  - hw/adc_channel_serializer.sv
  - hw/spi_adc_frontend.sv
  - target: test
    files:
      - bench/spi_adc_model.sv
      - bench/tb_spi_adc_frontend.sv
